/* verilog/div_pkg.sv */
// Shared definitions for the integer division unit
// Data and iteration widths, RV32M decode constants
// Operation enum and the sign/select tag carried along the pipe

package div_pkg;

  // Operand and result width
  localparam int DATA_WIDTH = 32;

  // Wide enough to hold an iteration count of 32
  localparam int ITER_WIDTH = 6;

  // R-type major opcode shared by base ALU and M-extension ops
  localparam logic [6:0] OPCODE_OP = 7'b0110011;

  // funct7 that selects MUL/DIV within OPCODE_OP
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Encoding follows funct3[1:0] of the division group (funct3[2] set)
  typedef enum logic [1:0] {
    op_div  = 2'b00, // funct3 100
    op_divu = 2'b01, // funct3 101
    op_rem  = 2'b10, // funct3 110
    op_remu = 2'b11  // funct3 111
  } div_op_e;

  // Post-processing applied to the unsigned core result
  typedef struct packed {
    logic neg_quotient;  // Operand signs differ, divisor nonzero
    logic neg_remainder; // Signed dividend was negative
    logic sel_remainder; // REM/REMU return the remainder
  } div_tag_t;

endpackage

/* verilog/div_op_if.sv */
// Decode-to-execute link of the division unit
// Load pulse, operand magnitudes, step count and sign tag
// decode modport drives, execute modport samples

`timescale 1ns/1ps

interface div_op_if import div_pkg::*; ();

  logic                  load;         // One-cycle pulse, payload valid
  logic [DATA_WIDTH-1:0] dividend_mag; // |rs1| for signed ops, rs1 otherwise
  logic [DATA_WIDTH-1:0] divisor_mag;  // |rs2| for signed ops, rs2 otherwise
  logic [ITER_WIDTH-1:0] iterations;   // Quotient bits to produce, 1..32
  div_tag_t              tag;          // Sign fix-up and result select

  // Decoder side
  modport decode (
    output load, dividend_mag, divisor_mag, iterations, tag
  );

  // Divider core side
  modport execute (
    input load, dividend_mag, divisor_mag, iterations, tag
  );

endinterface

/* verilog/div_decoder.sv */
// Decode stage of the division unit
// Recognises DIV/DIVU/REM/REMU, forms operand magnitudes
// Picks the iteration count for approximate mode and builds the sign tag

`timescale 1ns/1ps

module div_decoder import div_pkg::*; #(
  parameter int APX_ACC_CONTROL = 0 // 1 enables truncated DIV/DIVU
) (
  input  logic                  CLK,
  input  logic                  rst,
  input  logic                  start,
  input  logic [6:0]            opcode,
  input  logic [6:0]            funct7,
  input  logic [2:0]            funct3,
  input  logic [7:0]            accuracy_level,
  input  logic [DATA_WIDTH-1:0] rs1,
  input  logic [DATA_WIDTH-1:0] rs2,
  input  logic                  busy_in,
  div_op_if.decode              op
);

  div_op_e               op_kind;
  logic                  op_valid;
  logic                  signed_op;
  logic                  rs1_neg, rs2_neg;
  logic                  accept;
  logic [DATA_WIDTH-1:0] rs1_mag, rs2_mag;
  logic [ITER_WIDTH-1:0] iter_count;
  div_tag_t              tag_next;

  // Division group is funct3 1xx under the MULDIV funct7
  assign op_valid  = (opcode == OPCODE_OP) && (funct7 == FUNCT7_MULDIV) && funct3[2];
  assign op_kind   = div_op_e'(funct3[1:0]);
  assign signed_op = (op_kind == op_div) || (op_kind == op_rem);
  assign accept    = start && op_valid && !busy_in; // Invalid ops are simply dropped

  assign rs1_neg = signed_op && rs1[DATA_WIDTH-1];
  assign rs2_neg = signed_op && rs2[DATA_WIDTH-1];
  assign rs1_mag = rs1_neg ? -rs1 : rs1; // Most negative value maps onto itself, read unsigned
  assign rs2_mag = rs2_neg ? -rs2 : rs2;

  // Approximate mode only trims the quotient ops
  always_comb begin
    iter_count = ITER_WIDTH'(DATA_WIDTH);
    if ((APX_ACC_CONTROL == 1) && !op_kind[1] &&
        (accuracy_level != 8'd0) && (accuracy_level < DATA_WIDTH)) begin
      iter_count = accuracy_level[ITER_WIDTH-1:0];
    end
  end

  // Divide by zero keeps the all-ones quotient un-negated
  assign tag_next.neg_quotient  = (op_kind == op_div) && (rs1_neg ^ rs2_neg) && (rs2 != '0);
  assign tag_next.neg_remainder = (op_kind == op_rem) && rs1_neg;
  assign tag_next.sel_remainder = op_kind[1];

  always_ff @(posedge CLK) begin
    if (rst) op.load <= 1'b0;
    else     op.load <= accept;
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      op.dividend_mag <= rs1_mag;
      op.divisor_mag  <= rs2_mag;
      op.iterations   <= iter_count;
      op.tag          <= tag_next;
    end
  end

  // Issuing logic must wait for the whole unit to drain
  a_no_start_while_busy: assert property (@(posedge CLK) disable iff (rst)
    !(start && busy_in));

endmodule

/* verilog/div_restoring_core.sv */
// Execute stage of the division unit
// Restoring shift-subtract divider, one quotient bit per cycle
// Runs a variable number of steps and left-aligns a truncated quotient

`timescale 1ns/1ps

module div_restoring_core import div_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst,
  div_op_if.execute             op,
  output logic                  raw_valid,
  output logic [DATA_WIDTH-1:0] raw_quotient,
  output logic [DATA_WIDTH-1:0] raw_remainder,
  output div_tag_t              raw_tag,
  output logic                  busy
);

  // Control state
  logic                  running;   // Iterating
  logic [ITER_WIDTH-1:0] count;     // Steps still to run

  // Datapath registers
  logic [DATA_WIDTH-1:0] dividend_sr; // Dividend, MSB consumed first
  logic [DATA_WIDTH-1:0] divisor_q;
  logic [DATA_WIDTH-1:0] rem_q;       // Partial remainder, always below divisor
  logic [DATA_WIDTH-1:0] quotient_q;  // Bits enter from the right
  logic [ITER_WIDTH-1:0] n_iter;      // Step count kept for final alignment
  div_tag_t              tag_q;

  // Step logic
  logic [DATA_WIDTH:0]   rem_shift;   // One extra bit for the shifted remainder
  logic [DATA_WIDTH:0]   rem_trial;
  logic                  q_bit;
  logic [ITER_WIDTH-1:0] align_shift;

  assign rem_shift = {rem_q, dividend_sr[DATA_WIDTH-1]};
  assign rem_trial = rem_shift - {1'b0, divisor_q};
  assign q_bit     = !rem_trial[DATA_WIDTH]; // No borrow, so divisor fits

  always_ff @(posedge CLK) begin
    if (rst) begin
      running   <= 1'b0;
      raw_valid <= 1'b0;
      count     <= '0;
    end else begin
      raw_valid <= 1'b0;
      if (op.load) begin
        running <= 1'b1;
        count   <= op.iterations;
      end else if (running) begin
        count <= count - 1'b1;
        if (count == ITER_WIDTH'(1)) begin // Last step this edge
          running   <= 1'b0;
          raw_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (op.load) begin
      dividend_sr <= op.dividend_mag;
      divisor_q   <= op.divisor_mag;
      rem_q       <= '0;
      quotient_q  <= '0;
      n_iter      <= op.iterations;
      tag_q       <= op.tag;
    end else if (running) begin
      dividend_sr <= dividend_sr << 1;
      rem_q       <= q_bit ? rem_trial[DATA_WIDTH-1:0] : rem_shift[DATA_WIDTH-1:0]; // Restore
      quotient_q  <= {quotient_q[DATA_WIDTH-2:0], q_bit};
    end
  end

  // N steps give the top N quotient bits, so move them up and leave zeros below
  assign align_shift   = ITER_WIDTH'(DATA_WIDTH) - n_iter; // Zero for a full run
  assign raw_quotient  = quotient_q << align_shift;
  assign raw_remainder = rem_q;
  assign raw_tag       = tag_q;

  // Load counts as busy so the top level sees it the cycle after start
  assign busy = op.load || running || raw_valid;

  // Decoder only produces 1..32 steps
  a_iter_range: assert property (@(posedge CLK) disable iff (rst)
    op.load |-> (op.iterations >= ITER_WIDTH'(1)) &&
                (op.iterations <= ITER_WIDTH'(DATA_WIDTH)));

  // Busy feedback to the decoder must hold off a new operation
  a_no_load_while_busy: assert property (@(posedge CLK) disable iff (rst)
    op.load |-> !(running || raw_valid));

endmodule

/* verilog/div_result_select.sv */
// Result stage of the division unit
// Applies the sign fix-up to quotient and remainder
// Selects one of them and registers it with the done pulse

`timescale 1ns/1ps

module div_result_select import div_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst,
  input  logic                  raw_valid,
  input  logic [DATA_WIDTH-1:0] raw_quotient,
  input  logic [DATA_WIDTH-1:0] raw_remainder,
  input  div_tag_t              raw_tag,
  output logic [DATA_WIDTH-1:0] div_output,
  output logic                  div_done
);

  logic [DATA_WIDTH-1:0] quotient_s;  // Signed quotient
  logic [DATA_WIDTH-1:0] remainder_s; // Signed remainder
  logic [DATA_WIDTH-1:0] result_next;

  // Signed overflow has both operands negative, so 0x80000000 passes through un-negated
  assign quotient_s  = raw_tag.neg_quotient  ? -raw_quotient  : raw_quotient;
  assign remainder_s = raw_tag.neg_remainder ? -raw_remainder : raw_remainder; // Sign follows dividend

  assign result_next = raw_tag.sel_remainder ? remainder_s : quotient_s;

  always_ff @(posedge CLK) begin
    if (rst) begin
      div_done   <= 1'b0;
      div_output <= '0;
    end else begin
      div_done <= raw_valid; // Pulses for one cycle with no back-pressure
      if (raw_valid) begin
        div_output <= result_next; // Held until the next result
      end
    end
  end

endmodule

/* verilog/divider_unit.sv */
// Top level of the RV32M integer division unit
// Decode, restoring divider and result stages in a row
// Start strobe in, busy level and done pulse out

`timescale 1ns/1ps

module divider_unit import div_pkg::*; #(
  parameter int APX_ACC_CONTROL = 0 // 1 lets accuracy_level truncate DIV/DIVU
) (
  input  logic                  CLK,
  input  logic                  rst,
  input  logic                  start,
  input  logic [6:0]            opcode,
  input  logic [6:0]            funct7,
  input  logic [2:0]            funct3,
  input  logic [7:0]            accuracy_level,
  input  logic [DATA_WIDTH-1:0] rs1,
  input  logic [DATA_WIDTH-1:0] rs2,
  output logic                  div_unit_busy,
  output logic [DATA_WIDTH-1:0] div_output,
  output logic                  div_done
);

  div_op_if op_bus ();

  logic                  core_busy;
  logic                  raw_valid;
  logic [DATA_WIDTH-1:0] raw_quotient;
  logic [DATA_WIDTH-1:0] raw_remainder;
  div_tag_t              raw_tag;

  div_decoder #(
    .APX_ACC_CONTROL (APX_ACC_CONTROL)
  ) u_decoder (
    .CLK            (CLK),
    .rst            (rst),
    .start          (start),
    .opcode         (opcode),
    .funct7         (funct7),
    .funct3         (funct3),
    .accuracy_level (accuracy_level),
    .rs1            (rs1),
    .rs2            (rs2),
    .busy_in        (div_unit_busy),
    .op             (op_bus.decode)
  );

  div_restoring_core u_core (
    .CLK           (CLK),
    .rst           (rst),
    .op            (op_bus.execute),
    .raw_valid     (raw_valid),
    .raw_quotient  (raw_quotient),
    .raw_remainder (raw_remainder),
    .raw_tag       (raw_tag),
    .busy          (core_busy)
  );

  div_result_select u_result (
    .CLK           (CLK),
    .rst           (rst),
    .raw_valid     (raw_valid),
    .raw_quotient  (raw_quotient),
    .raw_remainder (raw_remainder),
    .raw_tag       (raw_tag),
    .div_output    (div_output),
    .div_done      (div_done)
  );

  // Result register stretches busy through the done cycle
  assign div_unit_busy = core_busy || div_done;

endmodule

/* dv/divider_checker.sv */
// Result checker for the division unit testbench
// Compares each done result with the expected value handed over by the bench
// Watches busy and done for protocol problems and counts errors

`timescale 1ns/1ps

module divider_checker #(
  parameter int NAME_BITS  = 160, // Packed test name, 8 bits per character
  parameter int BUSY_LIMIT = 40   // Longest legal busy stretch in cycles
) (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 div_unit_busy,
  input  logic                 div_done,
  input  logic [31:0]          div_output,
  input  logic [NAME_BITS-1:0] test_name,
  input  logic [31:0]          exp_value,
  input  logic                 exp_result, // Current entry should produce a result
  output int                   value_errors,
  output int                   protocol_errors,
  output int                   results_seen
);

  logic in_flight; // Valid op issued, done not seen yet
  int   busy_run;  // Consecutive busy cycles

  // Values read here are the ones that were stable through the last cycle
  always @(posedge CLK) begin
    if (rst) begin
      in_flight       <= 1'b0;
      busy_run        <= 0;
      value_errors    = 0;
      protocol_errors = 0;
      results_seen    = 0;
    end else begin
      busy_run <= div_unit_busy ? busy_run + 1 : 0;
      if (div_unit_busy && (busy_run == BUSY_LIMIT)) begin // Reported once per stretch
        protocol_errors = protocol_errors + 1;
        $display("%0s: busy stayed high for more than %0d cycles", test_name, BUSY_LIMIT);
      end
      if (div_done) begin
        in_flight    <= 1'b0;
        results_seen = results_seen + 1;
        if (!exp_result || !in_flight) begin
          protocol_errors = protocol_errors + 1;
          $display("%0s: a done pulse arrived with no operation in flight", test_name);
        end else if (div_output !== exp_value) begin
          value_errors = value_errors + 1;
          $display("Error: %0s expected %h actual %h", test_name, exp_value, div_output);
        end
      end
      // Busy must cover the whole span from start to done
      if (in_flight && !div_unit_busy) begin
        protocol_errors = protocol_errors + 1;
        $display("%0s: busy went low before the result was delivered", test_name);
      end
      if (!in_flight && div_unit_busy) begin // Also catches ignored ops that start the unit
        protocol_errors = protocol_errors + 1;
        $display("%0s: busy is high but no operation was issued", test_name);
      end
      if (start && exp_result) begin
        in_flight <= 1'b1; // Start sampled this edge
      end
    end
  end

endmodule

/* dv/divider_unit_tb.sv */
// Testbench for the RV32M division unit
// Clock and reset, directed stimulus table plus random DIVU/REMU entries
// Issues each entry, waits for done, then prints the final report

`timescale 1ns/1ps

module divider_unit_tb import div_pkg::*; ;

  localparam int         NAME_BITS = 8*20;
  localparam logic [2:0] F3_DIV    = 3'b100;
  localparam logic [2:0] F3_DIVU   = 3'b101;
  localparam logic [2:0] F3_REM    = 3'b110;
  localparam logic [2:0] F3_REMU   = 3'b111;

  // DUT inputs and outputs
  logic        CLK = 1'b0;
  logic        rst;
  logic        start;
  logic [6:0]  opcode;
  logic [6:0]  funct7;
  logic [2:0]  funct3;
  logic [7:0]  accuracy_level;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic        div_unit_busy;
  logic [31:0] div_output;
  logic        div_done;

  // Stimulus table with one queue per column
  logic [NAME_BITS-1:0] t_name[$];
  logic [6:0]           t_funct7[$];
  logic [2:0]           t_funct3[$];
  logic [6:0]           t_opcode[$];
  logic [31:0]          t_rs1[$];
  logic [31:0]          t_rs2[$];
  logic [7:0]           t_acc[$];
  logic [31:0]          t_expect[$];
  logic                 t_has_result[$];

  // Hand-off to the checker
  logic [NAME_BITS-1:0] cur_name;
  logic [31:0]          exp_value;
  logic                 exp_result;
  int                   value_errors;
  int                   protocol_errors;
  int                   results_seen;

  int seed        = 59;
  int cycle_count = 0;
  int cycle_limit = 1000; // Replaced once the table is built

  always #4 CLK = ~CLK; // 8 ns period

  divider_unit #(
    .APX_ACC_CONTROL (1)
  ) UUT (
    .CLK            (CLK),
    .rst            (rst),
    .start          (start),
    .opcode         (opcode),
    .funct7         (funct7),
    .funct3         (funct3),
    .accuracy_level (accuracy_level),
    .rs1            (rs1),
    .rs2            (rs2),
    .div_unit_busy  (div_unit_busy),
    .div_output     (div_output),
    .div_done       (div_done)
  );

  divider_checker #(
    .NAME_BITS (NAME_BITS)
  ) u_checker (
    .CLK             (CLK),
    .rst             (rst),
    .start           (start),
    .div_unit_busy   (div_unit_busy),
    .div_done        (div_done),
    .div_output      (div_output),
    .test_name       (cur_name),
    .exp_value       (exp_value),
    .exp_result      (exp_result),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .results_seen    (results_seen)
  );

  // Unsigned result by the M-extension rules including quotient truncation in approximate mode
  function automatic logic [31:0] expected_unsigned(input logic [31:0] a, input logic [31:0] b,
                                                    input logic [7:0] acc, input logic is_rem);
    logic [31:0] q;
    logic [31:0] r;
    if (b == 32'd0) begin
      q = 32'hFFFF_FFFF; // Divide by zero
      r = a;
    end else begin
      q = a / b;
      r = a % b;
    end
    if (is_rem) return r;
    if ((acc >= 8'd1) && (acc <= 8'd31)) q = q & (32'hFFFF_FFFF << (32 - acc)); // Keep top bits
    return q;
  endfunction

  task automatic add_entry(input logic [NAME_BITS-1:0] name, input logic [6:0] f7,
                           input logic [2:0] f3, input logic [6:0] opc, input logic [31:0] a,
                           input logic [31:0] b, input logic [7:0] acc, input logic [31:0] exp,
                           input logic has_result);
    t_name.push_back(name);
    t_funct7.push_back(f7);
    t_funct3.push_back(f3);
    t_opcode.push_back(opc);
    t_rs1.push_back(a);
    t_rs2.push_back(b);
    t_acc.push_back(acc);
    t_expect.push_back(exp);
    t_has_result.push_back(has_result);
  endtask

  // Hand-worked expected values with approximate mode enabled in the DUT
  task automatic build_directed();
    add_entry("div_pos", FUNCT7_MULDIV, F3_DIV, OPCODE_OP, 100, 7, 0, 32'h0000_000E, 1);
    add_entry("div_neg_divisor", FUNCT7_MULDIV, F3_DIV, OPCODE_OP, 20, -3, 0, 32'hFFFF_FFFA, 1);
    add_entry("rem_neg_divisor", FUNCT7_MULDIV, F3_REM, OPCODE_OP, 20, -3, 0, 32'h0000_0002, 1);
    add_entry("div_neg_dividend", FUNCT7_MULDIV, F3_DIV, OPCODE_OP, -20, 3, 0, 32'hFFFF_FFFA, 1);
    add_entry("rem_neg_dividend", FUNCT7_MULDIV, F3_REM, OPCODE_OP, -20, 3, 0, 32'hFFFF_FFFE, 1);
    add_entry("div_both_neg", FUNCT7_MULDIV, F3_DIV, OPCODE_OP, -20, -3, 0, 32'h0000_0006, 1);
    add_entry("rem_both_neg", FUNCT7_MULDIV, F3_REM, OPCODE_OP, -20, -3, 0, 32'hFFFF_FFFE, 1);
    add_entry("divu_big", FUNCT7_MULDIV, F3_DIVU, OPCODE_OP, 32'hFFFF_FFFE, 3, 0,
              32'h5555_5554, 1);
    add_entry("remu_big", FUNCT7_MULDIV, F3_REMU, OPCODE_OP, 32'hFFFF_FFFE, 3, 0, 32'h2, 1);
    // Divide by zero and signed overflow
    add_entry("div_by_zero", FUNCT7_MULDIV, F3_DIV, OPCODE_OP, -5, 0, 0, 32'hFFFF_FFFF, 1);
    add_entry("divu_by_zero", FUNCT7_MULDIV, F3_DIVU, OPCODE_OP, 1234, 0, 0, 32'hFFFF_FFFF, 1);
    add_entry("rem_by_zero", FUNCT7_MULDIV, F3_REM, OPCODE_OP, -5, 0, 0, 32'hFFFF_FFFB, 1);
    add_entry("remu_by_zero", FUNCT7_MULDIV, F3_REMU, OPCODE_OP, 1234, 0, 0, 32'h0000_04D2, 1);
    add_entry("div_overflow", FUNCT7_MULDIV, F3_DIV, OPCODE_OP, 32'h8000_0000, -1, 0,
              32'h8000_0000, 1);
    add_entry("rem_overflow", FUNCT7_MULDIV, F3_REM, OPCODE_OP, 32'h8000_0000, -1, 0, 0, 1);
    // 1000000000 / 3 = 0x13DE4355 remainder 1
    add_entry("divu_apx8", FUNCT7_MULDIV, F3_DIVU, OPCODE_OP, 1000000000, 3, 8,
              32'h1300_0000, 1);
    add_entry("div_apx8", FUNCT7_MULDIV, F3_DIV, OPCODE_OP, -1000000000, 3, 8,
              32'hED00_0000, 1); // Magnitude truncated, then negated
    add_entry("remu_apx8", FUNCT7_MULDIV, F3_REMU, OPCODE_OP, 1000000000, 3, 8, 1, 1);
    add_entry("divu_acc0", FUNCT7_MULDIV, F3_DIVU, OPCODE_OP, 1000000000, 3, 0,
              32'h13DE_4355, 1);
    add_entry("divu_acc40", FUNCT7_MULDIV, F3_DIVU, OPCODE_OP, 1000000000, 3, 40,
              32'h13DE_4355, 1);
    // Ops that are not divisions must be ignored
    add_entry("bad_funct7", 7'b0000000, F3_DIV, OPCODE_OP, 100, 7, 0, 0, 0);
    add_entry("bad_funct3", FUNCT7_MULDIV, 3'b000, OPCODE_OP, 100, 7, 0, 0, 0);
    add_entry("bad_opcode", FUNCT7_MULDIV, F3_DIV, 7'b0010011, 100, 7, 0, 0, 0);
    add_entry("divu_after_bad", FUNCT7_MULDIV, F3_DIVU, OPCODE_OP, 7, 2, 0, 32'h3, 1);
  endtask

  task automatic add_random(input int count);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [7:0]  acc;
    logic        is_rem;
    for (int k = 0; k < count; k++) begin
      a      = $random(seed);
      b      = $random(seed);
      r      = $random(seed);
      b      = b >> r[4:0];        // Spread divisor sizes for larger quotients
      acc    = r[15:8] % 8'd41;    // Range 0 to 40 covers exact and truncated runs
      is_rem = r[31];
      add_entry(is_rem ? "rand_remu" : "rand_divu", FUNCT7_MULDIV, is_rem ? F3_REMU : F3_DIVU,
                OPCODE_OP, a, b, acc, expected_unsigned(a, b, acc, is_rem), 1'b1);
    end
  endtask

  // Called on a rising edge and returns on the edge where the next entry may start
  task automatic run_entry(input int i);
    start          <= 1'b1;
    funct7         <= t_funct7[i];
    funct3         <= t_funct3[i];
    opcode         <= t_opcode[i];
    rs1            <= t_rs1[i];
    rs2            <= t_rs2[i];
    accuracy_level <= t_acc[i];
    cur_name       <= t_name[i];
    exp_value      <= t_expect[i];
    exp_result     <= t_has_result[i];
    @(posedge CLK);
    start <= 1'b0; // One-cycle strobe
    if (t_has_result[i]) begin
      while (!div_done) @(posedge CLK);
    end else begin
      repeat (4) @(posedge CLK); // Idle window for an ignored op
    end
  endtask

  initial begin
    rst            = 1'b1;
    start          = 1'b0;
    opcode         = '0;
    funct7         = '0;
    funct3         = '0;
    accuracy_level = '0;
    rs1            = '0;
    rs2            = '0;
    cur_name       = '0;
    exp_value      = '0;
    exp_result     = 1'b0;
    build_directed();
    add_random(16);
    cycle_limit = t_name.size() * 40 + 100;
    repeat (5) @(posedge CLK);
    rst <= 1'b0;
    @(posedge CLK);
    for (int i = 0; i < t_name.size(); i++) run_entry(i);
    repeat (4) @(posedge CLK);
    @(negedge CLK); // Checker counts from the last edge have settled
    $display("%0d entries, %0d results: %0d value errors, %0d protocol errors",
             t_name.size(), results_seen, value_errors, protocol_errors);
    if ((value_errors == 0) && (protocol_errors == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, a result never arrived", cycle_count);
      $display("test failed");
      $finish;
    end
  end

endmodule

/* vlog.f */
verilog/div_pkg.sv
verilog/div_op_if.sv
verilog/div_decoder.sv
verilog/div_restoring_core.sv
verilog/div_result_select.sv
verilog/divider_unit.sv
dv/divider_checker.sv
dv/divider_unit_tb.sv

/* Makefile */
# Verilator build and run for the division unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := divider_unit_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
